/* hdl/beat_timer.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module beat_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic play,
    output logic beat
);

    // counter is at least one bit wide even for a one-clock beat
    localparam int CNT_W = (`MUSIC_BEAT_CYCLES > 1) ? $clog2(`MUSIC_BEAT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`MUSIC_BEAT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    // --------------------------------------------------
    // prescaler
    // --------------------------------------------------
    // counts down while play is high and reloads after reaching zero
    // while play is low it holds, so a paused song resumes mid-beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= RELOAD;
        end else if (play) begin
            if (cnt == '0) begin
                cnt <= RELOAD;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // the strobe lands on the last clock of each beat period
    // play also gates it, so no beat is ever seen while paused
    assign beat = play && (cnt == '0);

endmodule

/* hdl/music_defines.svh */
`ifndef MUSIC_DEFINES_SVH
`define MUSIC_DEFINES_SVH

// --------------------------------------------------
// record field widths
// --------------------------------------------------

// note code width, code zero is silence or the end marker
`define MUSIC_NOTE_W 6

// duration and wait length, counted in beats
`define MUSIC_DUR_W 6

// record address inside one song
`define MUSIC_ADDR_W 8

// song select, four songs in the table
`define MUSIC_SONG_W 2

// full record as stored in the song table
`define MUSIC_REC_W 16

// --------------------------------------------------
// sequencer sizing
// --------------------------------------------------

// number of note players behind the arbiter
`define MUSIC_VOICES 3

// clocks per beat, small so that simulation stays short
`define MUSIC_BEAT_CYCLES 4

`endif

/* hdl/music_pkg.sv */
`include "music_defines.svh"

package music_pkg;

    // widths with a meaning of their own
    typedef logic [`MUSIC_NOTE_W-1:0] note_code_t;
    typedef logic [`MUSIC_DUR_W-1:0]  duration_t;
    typedef logic [`MUSIC_ADDR_W-1:0] song_addr_t;
    typedef logic [`MUSIC_SONG_W-1:0] song_sel_t;

    // one song table record, is_wait at the top and reserved option bits at the bottom
    // for a wait record the duration field holds the number of beats to hold off
    typedef struct packed {
        logic       is_wait;
        note_code_t note;
        duration_t  duration;
        logic [`MUSIC_REC_W-`MUSIC_NOTE_W-`MUSIC_DUR_W-2:0] options;
    } song_rec_t;

    // load command from the reader to one player, load is a single-cycle strobe
    typedef struct packed {
        logic       load;
        note_code_t note;
        duration_t  duration;
    } voice_cmd_t;

    // player status, note reads zero whenever the player is free
    typedef struct packed {
        logic       free;
        note_code_t note;
    } voice_status_t;

    typedef enum logic [2:0] {PAUSED, FETCH, DISPATCH, WAIT, ADVANCE} reader_state_t;

endpackage

/* hdl/music_sequencer.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module music_sequencer
    import music_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          play,
    input  song_sel_t     song_sel,
    output logic          song_done,
    output voice_cmd_t    voice_cmd [`MUSIC_VOICES],
    output voice_status_t voice_status [`MUSIC_VOICES]
);

    logic                                  beat;
    song_rec_t                             rec;
    logic [`MUSIC_SONG_W+`MUSIC_ADDR_W-1:0] rom_addr;
    logic [`MUSIC_VOICES-1:0]              free;
    logic [`MUSIC_VOICES-1:0]              grant;

    // --------------------------------------------------
    // reader, song table and beat source
    // --------------------------------------------------
    song_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song_sel  (song_sel),
        .beat      (beat),
        .rec       (rec),
        .grant     (grant),
        .rom_addr  (rom_addr),
        .cmd       (voice_cmd),
        .song_done (song_done)
    );

    song_rom u_rom (.clk(clk), .rom_addr(rom_addr), .rec(rec));

    beat_timer u_beat (.clk(clk), .rst_n(rst_n), .play(play), .beat(beat));

    // the arbiter sees only the free bit of each player status
    voice_arbiter u_arbiter (.free(free), .grant(grant));

    // --------------------------------------------------
    // note players
    // --------------------------------------------------
    for (genvar i = 0; i < `MUSIC_VOICES; i++) begin : g_voice
        assign free[i] = voice_status[i].free;

        note_player u_player (
            .clk    (clk),
            .rst_n  (rst_n),
            .beat   (beat),
            .play   (play),
            .cmd    (voice_cmd[i]),
            .status (voice_status[i])
        );
    end

endmodule

/* hdl/note_player.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module note_player
    import music_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          beat,
    input  logic          play,
    input  voice_cmd_t    cmd,
    output voice_status_t status
);

    duration_t  remain;
    note_code_t note_q;
    logic       free;

    // --------------------------------------------------
    // remaining beats
    // --------------------------------------------------
    // a load always wins, the arbiter only grants free players anyway
    // the count only moves on a beat taken while play is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (cmd.load) begin
            remain <= cmd.duration;
        end else if (beat && play && (remain != '0)) begin
            remain <= remain - 1'b1;
        end
    end

    // note code of the current load
    always_ff @(posedge clk) begin
        if (cmd.load) begin
            note_q <= cmd.note;
        end
    end

    // the player is free once its count has run out
    // a zero-length note therefore never shows as busy
    assign free = (remain == '0);

    assign status.free = free;
    assign status.note = free ? '0 : note_q;

    // the reader must only load through a grant, which the arbiter
    // gives to free players, so a load on a busy voice is a fault upstream
    a_load_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.load |-> free)
        else $error("load arrived while player busy, remain %h", remain);

endmodule

/* hdl/song_reader.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module song_reader
    import music_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  play,
    input  song_sel_t                             song_sel,
    input  logic                                  beat,
    input  song_rec_t                             rec,
    input  logic [`MUSIC_VOICES-1:0]              grant,
    output logic [`MUSIC_SONG_W+`MUSIC_ADDR_W-1:0] rom_addr,
    output voice_cmd_t                            cmd [`MUSIC_VOICES],
    output logic                                  song_done
);

    reader_state_t state;
    reader_state_t next_state;
    song_addr_t    addr;
    song_sel_t     song_q;
    duration_t     wait_cnt;
    logic          done_hold;
    logic          is_end;
    logic          is_note;
    logic          send;
    logic [`MUSIC_VOICES-1:0] loads;

    // the rom sees the latched song, not the live select input
    assign rom_addr = {song_q, addr};

    // record decode, the end marker is a note record with code zero
    assign is_end  = !rec.is_wait && (rec.note == '0);
    assign is_note = !rec.is_wait && (rec.note != '0);

    // a note goes out only in DISPATCH, with play high and a free player
    assign send      = (state == DISPATCH) && play && is_note && (|grant);
    assign song_done = (state == DISPATCH) && play && is_end;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        if (!play) begin
            // dropping play parks the reader wherever it was
            next_state = PAUSED;
        end else begin
            case (state)
                // after an end marker, wait for play to fall and rise again
                PAUSED:   if (!done_hold) next_state = FETCH;
                FETCH:    next_state = DISPATCH;
                DISPATCH: begin
                    if (rec.is_wait) begin
                        next_state = WAIT;
                    end else if (is_end) begin
                        next_state = PAUSED;
                    end else if (|grant) begin
                        next_state = FETCH;
                    end
                end
                WAIT:     if (wait_cnt == '0) next_state = ADVANCE;
                ADVANCE:  next_state = FETCH;
                default:  next_state = PAUSED;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= PAUSED;
            done_hold <= 1'b0;
        end else begin
            state <= next_state;
            if (song_done) begin
                done_hold <= 1'b1;
            end else if (!play) begin
                done_hold <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // song number and address counter
    // --------------------------------------------------
    // the select is only taken while paused and a new song starts at record zero
    // a pause elsewhere keeps the address, so a paused wait is fetched again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            song_q <= '0;
            addr   <= '0;
        end else if ((state == PAUSED) && (song_sel != song_q)) begin
            song_q <= song_sel;
            addr   <= '0;
        end else if (song_done) begin
            addr <= '0;
        end else if (send || ((state == ADVANCE) && play)) begin
            addr <= addr + 1'b1;
        end
    end

    // wait countdown, loaded from the wait record and run down on beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if ((state == DISPATCH) && play && rec.is_wait) begin
            wait_cnt <= rec.duration;
        end else if ((state == WAIT) && beat && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // --------------------------------------------------
    // command fan-out
    // --------------------------------------------------
    // only the granted player sees the note, the others get an idle command
    always_comb begin
        for (int i = 0; i < `MUSIC_VOICES; i++) begin
            loads[i]        = send && grant[i];
            cmd[i].load     = loads[i];
            cmd[i].note     = loads[i] ? rec.note : '0;
            cmd[i].duration = loads[i] ? rec.duration : '0;
        end
    end

    // one record feeds one player, which relies on the arbiter grant being one-hot
    a_single_load: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(loads))
        else $error("more than one load strobe, loads %h", loads);

    a_done_no_load: assert property (@(posedge clk) disable iff (!rst_n)
        song_done |-> (loads == '0))
        else $error("song_done together with load, loads %h", loads);

endmodule

/* hdl/song_rom.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module song_rom
    import music_pkg::*;
(
    input  logic                                  clk,
    input  logic [`MUSIC_SONG_W+`MUSIC_ADDR_W-1:0] rom_addr,
    output song_rec_t                             rec
);

    // builds a note record, option bits stay zero
    function automatic song_rec_t note_rec(input note_code_t n, input duration_t d);
        song_rec_t r;
        r          = '0;
        r.note     = n;
        r.duration = d;
        return r;
    endfunction

    // builds a wait record holding off the next record for b beats
    function automatic song_rec_t wait_rec(input duration_t b);
        song_rec_t r;
        r          = '0;
        r.is_wait  = 1'b1;
        r.duration = b;
        return r;
    endfunction

    // --------------------------------------------------
    // song table, upper two address bits pick the song
    // --------------------------------------------------
    // any address not listed reads as all zeros, which is the end marker
    // song 3 is not listed at all, so it ends on its first record
    always_ff @(posedge clk) begin
        case (rom_addr)
            // song 0 has three notes, a rest, two more notes
            {2'd0, 8'd0}: rec <= note_rec(6'd20, 6'd2);
            {2'd0, 8'd1}: rec <= note_rec(6'd24, 6'd1);
            {2'd0, 8'd2}: rec <= note_rec(6'd27, 6'd3);
            {2'd0, 8'd3}: rec <= wait_rec(6'd3);
            {2'd0, 8'd4}: rec <= note_rec(6'd32, 6'd2);
            {2'd0, 8'd5}: rec <= note_rec(6'd15, 6'd1);
            // song 1 keeps all three players busy so the fourth note stalls
            {2'd1, 8'd0}: rec <= note_rec(6'd36, 6'd12);
            {2'd1, 8'd1}: rec <= note_rec(6'd40, 6'd10);
            {2'd1, 8'd2}: rec <= note_rec(6'd43, 6'd6);
            {2'd1, 8'd3}: rec <= note_rec(6'd48, 6'd4);
            // song 2 is short and ends on a zero-length note
            {2'd2, 8'd0}: rec <= note_rec(6'd40, 6'd3);
            {2'd2, 8'd1}: rec <= note_rec(6'd43, 6'd3);
            {2'd2, 8'd2}: rec <= wait_rec(6'd2);
            {2'd2, 8'd3}: rec <= note_rec(6'd47, 6'd1);
            {2'd2, 8'd4}: rec <= note_rec(6'd50, 6'd0);
            default:      rec <= '0;
        endcase
    end

endmodule

/* hdl/voice_arbiter.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module voice_arbiter (
    input  logic [`MUSIC_VOICES-1:0] free,
    output logic [`MUSIC_VOICES-1:0] grant
);

    logic taken;

    // fixed priority, the lowest-numbered free player wins
    // grant stays all zero when every player is busy
    always_comb begin
        grant = '0;
        taken = 1'b0;
        for (int i = 0; i < `MUSIC_VOICES; i++) begin
            if (free[i] && !taken) begin
                grant[i] = 1'b1;
                taken    = 1'b1;
            end
        end
    end

    // the reader fans the note by grant bits, so a second bit would double-load
    // and a grant to a busy player would cut off a note still sounding
    always_comb begin
        a_grant_legal: assert final ($onehot0(grant) && ((grant & ~free) == '0))
            else $error("grant %h is not a one-hot pick of free %h", grant, free);
    end

endmodule

/* music_sequencer.f */
+incdir+hdl
hdl/music_pkg.sv
hdl/song_rom.sv
hdl/beat_timer.sv
hdl/voice_arbiter.sv
hdl/note_player.sv
hdl/song_reader.sv
hdl/music_sequencer.sv
verification/music_sequencer_tb.sv

/* verification/music_sequencer_tb.sv */
`timescale 1ns/1ns
`include "music_defines.svh"

module music_sequencer_tb
    import music_pkg::*;
();

    localparam int NV   = `MUSIC_VOICES;
    localparam int BEAT = `MUSIC_BEAT_CYCLES;

    logic          clk;
    logic          rst_n;
    logic          play;
    song_sel_t     song_sel;
    logic          song_done;
    voice_cmd_t    voice_cmd [NV];
    voice_status_t voice_status [NV];

    // expected records per song in table order, a voice of -1 is left to the model
    song_rec_t exp_tab [4][8];
    int        exp_voice [4][8];
    int        exp_len [4];
    logic      table_ready;

    // reference model of the players and the progress through the current song
    int            model_rem [NV];
    note_code_t    model_note [NV];
    voice_status_t exp_stat;
    logic          model_beat;
    logic          all_free;
    int            play_cycles;
    int            beats_since;
    int            skip_cycles;
    int            need_beats;
    int            n_loads;
    int            load_v;
    int            lowest;
    int            cur_song;
    int            idx;
    logic          pause_run;
    logic          done_seen;
    logic [31:0]   rng;

    music_sequencer u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .play         (play),
        .song_sel     (song_sel),
        .song_done    (song_done),
        .voice_cmd    (voice_cmd),
        .voice_status (voice_status)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic add_rec(input int s, input int v, input logic w, input int n, input int d);
        song_rec_t e;
        e          = '0;
        e.is_wait  = w;
        e.note     = note_code_t'(n);
        e.duration = duration_t'(d);
        exp_tab[s][exp_len[s]]   = e;
        exp_voice[s][exp_len[s]] = v;
        exp_len[s]++;
    endtask

    // --------------------------------------------------
    // table walk
    // --------------------------------------------------
    // wait records ahead of the next record add up to a minimum number of beats
    task automatic skip_waits();
        song_rec_t e;
        e = exp_tab[cur_song][idx];
        while ((idx < exp_len[cur_song]) && e.is_wait) begin
            need_beats += e.duration;
            idx++;
            e = exp_tab[cur_song][idx];
        end
        assert (beats_since >= need_beats) else begin
            $display("wait cut short in song %0d, %0d beats of %0d", cur_song, beats_since,
                     need_beats);
            stop_run();
        end
        assert (idx < exp_len[cur_song]) else begin
            $display("song %0d went on past the end of its table", cur_song);
            stop_run();
        end
    endtask

    task automatic check_dispatch();
        song_rec_t  e;
        voice_cmd_t c;
        c = voice_cmd[load_v];
        assert ((n_loads == 1) && play) else begin
            $display("%0d load strobes in one cycle with play %b", n_loads, play);
            stop_run();
        end
        assert (load_v == lowest) else begin
            $display("ERR voice_cmd load voice exp %h got %h", lowest, load_v);
            stop_run();
        end
        skip_waits();
        e = exp_tab[cur_song][idx];
        assert ((c.note == e.note) && (c.duration == e.duration)) else begin
            $display("ERR voice_cmd[%0d] note,duration exp %h,%h got %h,%h", load_v, e.note,
                     e.duration, c.note, c.duration);
            stop_run();
        end
        // with pauses the beat phase moves, so only the model picks the voice then
        assert (pause_run || (exp_voice[cur_song][idx] < 0) ||
                (exp_voice[cur_song][idx] == load_v)) else begin
            $display("ERR voice_cmd load voice exp %h got %h", exp_voice[cur_song][idx], load_v);
            stop_run();
        end
        idx++;
        need_beats  = 0;
        beats_since = 0;
        skip_cycles = 3;
    endtask

    task automatic check_done();
        song_rec_t e;
        skip_waits();
        e = exp_tab[cur_song][idx];
        assert (!e.is_wait && (e.note == '0)) else begin
            $display("song_done came early in song %0d at record %0d", cur_song, idx);
            stop_run();
        end
        idx++;
        need_beats  = 0;
        beats_since = 0;
        done_seen   = 1'b1;
    endtask

    // --------------------------------------------------
    // monitor and player model, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            // the prescaler starts at its reload value, so every fourth play-high clock beats
            model_beat = play && ((play_cycles % BEAT) == (BEAT - 1));
            if (play) begin
                play_cycles++;
            end
            n_loads = 0;
            load_v  = -1;
            lowest  = -1;
            for (int i = NV - 1; i >= 0; i--) begin
                exp_stat.free = (model_rem[i] == 0);
                exp_stat.note = exp_stat.free ? note_code_t'(0) : model_note[i];
                assert (voice_status[i] == exp_stat) else begin
                    $display("ERR voice_status[%0d] exp %h got %h", i, exp_stat, voice_status[i]);
                    stop_run();
                end
                if (exp_stat.free) begin
                    lowest = i;
                end
                if (voice_cmd[i].load) begin
                    n_loads++;
                    load_v = i;
                end
            end
            if (n_loads > 0) begin
                check_dispatch();
            end
            if (song_done) begin
                check_done();
            end
            // the reader reaches WAIT no earlier than the third play-high clock after a
            // dispatch, so beats before that and the beat of a dispatch clock are not wait beats
            if (model_beat && (skip_cycles == 0)) begin
                beats_since++;
            end
            if (play && (skip_cycles > 0)) begin
                skip_cycles--;
            end
            // a load wins over a beat in the same cycle
            all_free = 1'b1;
            for (int i = 0; i < NV; i++) begin
                if (voice_cmd[i].load) begin
                    model_rem[i]  = voice_cmd[i].duration;
                    model_note[i] = voice_cmd[i].note;
                end else if (model_beat && (model_rem[i] != 0)) begin
                    model_rem[i]--;
                end
                if (model_rem[i] != 0) begin
                    all_free = 1'b0;
                end
            end
        end
    end

    // select a song while paused, play it to its end, then let the players drain
    task automatic play_song(input int s, input logic pauses);
        int gap;
        @(posedge clk);
        #1;
        play        = 1'b0;
        song_sel    = song_sel_t'(s);
        cur_song    = s;
        pause_run   = pauses;
        idx         = 0;
        need_beats  = 0;
        beats_since = 0;
        skip_cycles = 0;
        done_seen   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        play = 1'b1;
        while (!done_seen) begin
            @(posedge clk);
            #1;
            if (pauses && !done_seen && ((next_random() % 8) == 0)) begin
                gap  = 1 + (next_random() % 4);
                play = 1'b0;
                repeat (gap) @(posedge clk);
                #1;
                play = 1'b1;
            end
        end
        while (!all_free) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        play        = 1'b0;
        song_sel    = '0;
        table_ready = 1'b0;
        rng         = 32'hc63e0abe;
        play_cycles = 0;
        skip_cycles = 0;
        all_free    = 1'b1;
        for (int i = 0; i < NV; i++) begin
            model_rem[i]  = 0;
            model_note[i] = '0;
        end
        for (int s = 0; s < 4; s++) begin
            exp_len[s] = 0;
        end
        // song 0, the third note lands on voice 1 or 2 depending on the beat phase
        add_rec(0, 0, 1'b0, 20, 2);
        add_rec(0, 1, 1'b0, 24, 1);
        add_rec(0, -1, 1'b0, 27, 3);
        add_rec(0, -1, 1'b1, 0, 3);
        add_rec(0, 0, 1'b0, 32, 2);
        add_rec(0, 1, 1'b0, 15, 1);
        add_rec(0, -1, 1'b0, 0, 0);
        // song 1, the fourth note stalls until voice 2 runs out first
        add_rec(1, 0, 1'b0, 36, 12);
        add_rec(1, 1, 1'b0, 40, 10);
        add_rec(1, 2, 1'b0, 43, 6);
        add_rec(1, 2, 1'b0, 48, 4);
        add_rec(1, -1, 1'b0, 0, 0);
        add_rec(2, 0, 1'b0, 40, 3);
        add_rec(2, 1, 1'b0, 43, 3);
        add_rec(2, -1, 1'b1, 0, 2);
        add_rec(2, -1, 1'b0, 47, 1);
        add_rec(2, -1, 1'b0, 50, 0);
        add_rec(2, -1, 1'b0, 0, 0);
        add_rec(3, -1, 1'b0, 0, 0);
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // first pass plays straight through, the second drops play at random points
        for (int pass = 0; pass < 2; pass++) begin
            for (int s = 0; s < 4; s++) begin
                play_song(s, pass == 1);
            end
        end
        $display(">>> PASS");
        $finish;
    end

    // watchdog sized from the table, doubled durations cover pauses and draining
    initial begin
        int        sum_dur;
        int        n_rec;
        int        limit;
        song_rec_t e;
        wait (table_ready === 1'b1);
        sum_dur = 0;
        n_rec   = 0;
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < exp_len[s]; r++) begin
                e = exp_tab[s][r];
                sum_dur += e.duration;
                n_rec++;
            end
        end
        limit = 2 * (2 * sum_dur * BEAT + 16 * n_rec + 40) + 20;
        repeat (limit) @(posedge clk);
        $display("timeout, the songs did not finish within %0d clocks", limit);
        stop_run();
    end

endmodule
